// File: hdl/stopwatchPkg.sv
package stopwatchPkg;

    ////////////////////////////////////////
    // display geometry
    ////////////////////////////////////////
    localparam int DigitCount = 8;             // digits on the board
    localparam int DigitBits  = 4;             // one BCD nibble per digit
    localparam int ScanBits   = 3;             // one digit lit per cycle

    // decimal points after seconds, minutes and hours
    localparam logic [DigitCount-1:0] SeparatorMask = 8'b0101_0100;

    ////////////////////////////////////////
    // timing
    ////////////////////////////////////////
    localparam int TickDivide = 4;             // enabled cycles per hundredth, sim sized
    localparam int PhaseBits  = $clog2(TickDivide);

    typedef logic [DigitBits-1:0]            digitT;
    typedef logic [DigitCount*DigitBits-1:0] timeDigitsT;
    typedef logic [7:0]                      segmentT;   // bit 7 is dp, all active low
    typedef logic [DigitCount-1:0]           anodeT;     // one-hot, active high
    typedef logic [PhaseBits-1:0]            phaseT;

    // highest value per digit, HH:MM:SS.hh from digit 7 down to digit 0
    localparam timeDigitsT DigitMax = 32'h9959_5999;

    ////////////////////////////////////////
    // control FSM
    ////////////////////////////////////////
    typedef enum logic [1:0]
    {
        Idle,
        Running,
        Paused,
        LapHold
    } controlStateT;

endpackage

// File: hdl/stopwatchControl.sv
module stopwatchControl
(
    input  logic clk,
    input  logic reset_n,
    input  logic startStop,      // one-cycle strobe
    input  logic lap,            // one-cycle strobe
    output logic countEnable,
    output logic clearCount,
    output logic freezeDisplay,
    output logic separatorOn
);

    stopwatchPkg::controlStateT state;
    stopwatchPkg::controlStateT nextState;
    logic                       goIdle;

    ////////////////////////////////////////
    // transitions
    ////////////////////////////////////////
    always_comb
    begin
        nextState = state;
        // startStop takes priority when both strobes land together
        case (state)
            stopwatchPkg::Idle:
            begin
                if (startStop)
                    nextState = stopwatchPkg::Running;
            end
            stopwatchPkg::Running:
            begin
                if (startStop)
                    nextState = stopwatchPkg::Paused;
                else if (lap)
                    nextState = stopwatchPkg::LapHold;
            end
            stopwatchPkg::Paused:
            begin
                if (startStop)
                    nextState = stopwatchPkg::Running;
                else if (lap)
                    nextState = stopwatchPkg::Idle;   // also clears the count
            end
            stopwatchPkg::LapHold:
            begin
                if (startStop)
                    nextState = stopwatchPkg::Paused;
                else if (lap)
                    nextState = stopwatchPkg::Running;
            end
            default:
                nextState = stopwatchPkg::Idle;
        endcase
    end

    assign goIdle = (state == stopwatchPkg::Paused) && (nextState == stopwatchPkg::Idle);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state      <= stopwatchPkg::Idle;
            clearCount <= 1'b0;
        end
        else
        begin
            state      <= nextState;
            clearCount <= goIdle;       // single pulse on the way back to idle
        end
    end

    // level outputs straight from the state
    assign countEnable   = (state == stopwatchPkg::Running) || (state == stopwatchPkg::LapHold);
    assign freezeDisplay = (state == stopwatchPkg::LapHold);
    assign separatorOn   = countEnable;

endmodule

// File: hdl/tickTimer.sv
module tickTimer
(
    input  logic clk,
    input  logic reset_n,
    input  logic countEnable,
    input  logic clearCount,
    output logic tick            // one cycle per hundredth
);

    localparam stopwatchPkg::phaseT LastPhase =
        stopwatchPkg::phaseT'(stopwatchPkg::TickDivide - 1);

    stopwatchPkg::phaseT phase;
    logic                phaseEnd;

    assign phaseEnd = (phase == LastPhase);
    assign tick     = countEnable && phaseEnd;

    // phase is held while paused so no partial hundredth is lost
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            phase <= '0;
        else if (clearCount)
            phase <= '0;
        else if (countEnable)
        begin
            if (phaseEnd)
                phase <= '0;            // wrap with the tick
            else
                phase <= phase + 1'b1;
        end
    end

endmodule

// File: hdl/bcdTimeCounter.sv
module bcdTimeCounter
(
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     tick,
    input  logic                     clearCount,
    input  logic                     freezeDisplay,
    output stopwatchPkg::timeDigitsT shownDigits
);

    stopwatchPkg::timeDigitsT liveDigits;
    stopwatchPkg::timeDigitsT liveNext;

    ////////////////////////////////////////
    // mixed radix increment
    ////////////////////////////////////////
    // each digit rolls over at its own limit from DigitMax,
    // the carry ripples upward from hundredths
    function automatic stopwatchPkg::timeDigitsT incrementTime
    (
        input stopwatchPkg::timeDigitsT current
    );
        stopwatchPkg::timeDigitsT result;
        stopwatchPkg::digitT      digit;
        stopwatchPkg::digitT      limit;
        logic                     carry;

        result = current;
        carry  = 1'b1;
        for (int i = 0; i < stopwatchPkg::DigitCount; i++)
        begin
            digit = current[i*stopwatchPkg::DigitBits +: stopwatchPkg::DigitBits];
            limit = stopwatchPkg::DigitMax[i*stopwatchPkg::DigitBits +: stopwatchPkg::DigitBits];
            if (carry)
            begin
                if (digit == limit)
                    digit = '0;                 // roll over, carry moves on
                else
                begin
                    digit = digit + 1'b1;
                    carry = 1'b0;
                end
            end
            result[i*stopwatchPkg::DigitBits +: stopwatchPkg::DigitBits] = digit;
        end
        // past 99:59:59.99 every digit has rolled, so the result is all zero
        return result;
    endfunction

    assign liveNext = tick ? incrementTime(liveDigits) : liveDigits;

    ////////////////////////////////////////
    // live count and display copy
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            liveDigits <= '0;
        else if (clearCount)
            liveDigits <= '0;
        else
            liveDigits <= liveNext;
    end

    // display tracks the live count in step unless a lap is held
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            shownDigits <= '0;
        else if (clearCount)
            shownDigits <= '0;
        else if (!freezeDisplay)
            shownDigits <= liveNext;
    end

endmodule

// File: hdl/ledScan.sv
module ledScan
(
    input  logic                     clk,
    input  logic                     reset_n,
    input  stopwatchPkg::timeDigitsT shownDigits,
    input  logic                     separatorOn,
    output stopwatchPkg::segmentT    ledCode,
    output stopwatchPkg::anodeT      an
);

    logic [stopwatchPkg::ScanBits-1:0] scanCount;
    stopwatchPkg::digitT               hexIn;
    logic                              dp;

    ////////////////////////////////////////
    // scan counter
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            scanCount <= '0;
        else
            scanCount <= scanCount + 1'b1;      // next digit every cycle
    end

    ////////////////////////////////////////
    // digit select
    ////////////////////////////////////////
    always_comb
    begin
        an    = stopwatchPkg::anodeT'(1) << scanCount;   // high enables the digit
        hexIn = shownDigits[scanCount*stopwatchPkg::DigitBits +: stopwatchPkg::DigitBits];
        // point is active low, lit only on separator digits
        dp    = ~(separatorOn & stopwatchPkg::SeparatorMask[scanCount]);
    end

    ////////////////////////////////////////
    // seven segment decode
    ////////////////////////////////////////
    // common anode, segment bits g..a, low lights the segment
    always_comb
    begin
        case (hexIn)
            4'h0:    ledCode[6:0] = 7'b100_0000;
            4'h1:    ledCode[6:0] = 7'b111_1001;
            4'h2:    ledCode[6:0] = 7'b010_0100;
            4'h3:    ledCode[6:0] = 7'b011_0000;
            4'h4:    ledCode[6:0] = 7'b001_1001;
            4'h5:    ledCode[6:0] = 7'b001_0010;
            4'h6:    ledCode[6:0] = 7'b000_0010;
            4'h7:    ledCode[6:0] = 7'b111_1000;
            4'h8:    ledCode[6:0] = 7'b000_0000;
            4'h9:    ledCode[6:0] = 7'b001_0000;
            4'hA:    ledCode[6:0] = 7'b000_1000;  // hex letters, never seen in BCD
            4'hB:    ledCode[6:0] = 7'b000_0011;
            4'hC:    ledCode[6:0] = 7'b100_0110;
            4'hD:    ledCode[6:0] = 7'b010_0001;
            4'hE:    ledCode[6:0] = 7'b000_0110;
            4'hF:    ledCode[6:0] = 7'b000_1110;
            default: ledCode[6:0] = 7'b100_0000;
        endcase
        ledCode[7] = dp;
    end

endmodule

// File: hdl/stopwatchTop.sv
module stopwatchTop
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  startStop,    // debounced strobe
    input  logic                  lap,          // debounced strobe
    output stopwatchPkg::segmentT ledCode,
    output stopwatchPkg::anodeT   an
);

    logic                     countEnable;
    logic                     clearCount;
    logic                     freezeDisplay;
    logic                     separatorOn;
    logic                     tick;
    stopwatchPkg::timeDigitsT shownDigits;

    ////////////////////////////////////////
    // control and timebase
    ////////////////////////////////////////
    stopwatchControl stopwatchControl_inst
    (
        .clk           (clk),
        .reset_n       (reset_n),
        .startStop     (startStop),
        .lap           (lap),
        .countEnable   (countEnable),
        .clearCount    (clearCount),
        .freezeDisplay (freezeDisplay),
        .separatorOn   (separatorOn)
    );

    tickTimer tickTimer_inst
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .countEnable (countEnable),
        .clearCount  (clearCount),
        .tick        (tick)
    );

    ////////////////////////////////////////
    // count and display
    ////////////////////////////////////////
    bcdTimeCounter bcdTimeCounter_inst
    (
        .clk           (clk),
        .reset_n       (reset_n),
        .tick          (tick),
        .clearCount    (clearCount),
        .freezeDisplay (freezeDisplay),
        .shownDigits   (shownDigits)
    );

    ledScan ledScan_inst
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .shownDigits (shownDigits),
        .separatorOn (separatorOn),
        .ledCode     (ledCode),
        .an          (an)
    );

endmodule

// File: tb/stopwatchProps.sv
module stopwatchProps
(
    input logic                     clk,
    input logic                     reset_n,
    input stopwatchPkg::anodeT      an,
    input stopwatchPkg::timeDigitsT shownDigits,
    input logic                     freezeDisplay,
    input logic                     clearCount
);

    ////////////////////////////////////////
    // scan rotation
    ////////////////////////////////////////
    anodeOneHot: assert property (@(posedge clk) disable iff (!reset_n) $onehot(an))
        else $error("anode select is not one-hot");

    // one position per cycle, digit 7 wraps to digit 0
    anodeRotates: assert property (@(posedge clk) disable iff (!reset_n)
        $past(reset_n) |-> an == {$past(an[6:0]), $past(an[7])})
        else $error("anode select did not rotate by one digit");

    ////////////////////////////////////////
    // display and clear
    ////////////////////////////////////////
    frozenDisplay: assert property (@(posedge clk) disable iff (!reset_n)
        freezeDisplay && !clearCount |=> $stable(shownDigits))
        else $error("shown digits changed during a lap hold");

    clearSingle: assert property (@(posedge clk) disable iff (!reset_n)
        clearCount |=> !clearCount)
        else $error("clear pulse lasted more than one cycle");

endmodule

bind stopwatchTop stopwatchProps stopwatchProps_inst
(
    .clk           (clk),
    .reset_n       (reset_n),
    .an            (an),
    .shownDigits   (shownDigits),
    .freezeDisplay (freezeDisplay),
    .clearCount    (clearCount)
);

// File: tb/stopwatchTb.sv
module stopwatchTb;

    logic                  clk;
    logic                  reset_n;
    logic                  startStop;
    logic                  lap;
    stopwatchPkg::segmentT ledCode;
    stopwatchPkg::anodeT   an;

    int errorCount;
    int testErrors;
    int testCount;
    int failedTests;
    int enabledCycles;          // enabled cycles since the last clear

    stopwatchTop stopwatchTop_inst
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .startStop (startStop),
        .lap       (lap),
        .ledCode   (ledCode),
        .an        (an)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////
    // models and helpers
    ////////////////////////////////////////
    // common anode patterns, segments g..a
    function automatic int segmentsToDigit(input logic [6:0] segments);
        case (segments)
            7'h40:   return 0;
            7'h79:   return 1;
            7'h24:   return 2;
            7'h30:   return 3;
            7'h19:   return 4;
            7'h12:   return 5;
            7'h02:   return 6;
            7'h78:   return 7;
            7'h00:   return 8;
            7'h10:   return 9;
            default: return -1;
        endcase
    endfunction

    // hundredths to HH:MM:SS.hh, two BCD digits per field
    function automatic stopwatchPkg::timeDigitsT expectedDigits(input int hundredths);
        int                       fields [4];
        stopwatchPkg::timeDigitsT digits;

        fields[0] = hundredths % 100;
        fields[1] = (hundredths / 100) % 60;
        fields[2] = (hundredths / 6000) % 60;
        fields[3] = (hundredths / 360000) % 100;
        digits = '0;
        for (int i = 0; i < 4; i++)
        begin
            digits[i*8 +: 4]     = 4'(fields[i] % 10);
            digits[i*8 + 4 +: 4] = 4'(fields[i] / 10);
        end
        return digits;
    endfunction

    task automatic countError();
        errorCount++;
        testErrors++;
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual == expected)
        else
        begin
            $display("FAILED %s expected %h got %h", name, expected, actual);
            countError();
        end
    endtask

    task automatic finishTest(input string name);
        testCount++;
        if (testErrors == 0)
            $display("test %s passed", name);
        else
        begin
            failedTests++;
            $display("test %s failed with %0d errors", name, testErrors);
        end
        testErrors = 0;
    endtask

    // strobes are set on a falling edge and dropped on the next one
    task automatic pulseStartStop();
        startStop = 1'b1;
        @(negedge clk);
        startStop = 1'b0;
    endtask

    task automatic pulseLap();
        lap = 1'b1;
        @(negedge clk);
        lap = 1'b0;
    endtask

    // start, then stop so that exactly 'cycles' edges are enabled
    task automatic countFor(input int cycles);
        pulseStartStop();
        repeat (cycles - 1) @(negedge clk);
        pulseStartStop();
        enabledCycles += cycles;
    endtask

    // collect one full scan, sampled on falling edges
    task automatic readDisplay(output stopwatchPkg::timeDigitsT digits,
                               output logic [7:0] points, output int used);
        logic [7:0] seen;
        int         index;
        int         value;

        seen   = '0;
        used   = 0;
        digits = '0;
        points = '0;
        while (seen != 8'hFF && used < 40)
        begin
            @(negedge clk);
            used++;
            index = 0;
            if ($countones(an) != 1)
            begin
                $display("anode select is not one-hot during a display read");
                countError();
            end
            else
            begin
                for (int i = 0; i < stopwatchPkg::DigitCount; i++)
                    if (an[i])
                        index = i;
                value = segmentsToDigit(ledCode[6:0]);
                if (value < 0)
                begin
                    $display("unknown segment pattern %h on digit %0d", ledCode[6:0], index);
                    countError();
                end
                else
                    digits[index*4 +: 4] = 4'(value);
                points[index] = ~ledCode[7];    // lit point reads as 1
                seen[index]   = 1'b1;
            end
        end
        if (seen != 8'hFF)
        begin
            $display("timed out waiting for every anode to be selected");
            countError();
        end
    endtask

    task automatic checkDisplay(input int hundredths, input logic [7:0] expectedPoints);
        stopwatchPkg::timeDigitsT digits;
        logic [7:0]               points;
        int                       used;

        readDisplay(digits, points, used);
        checkValue("shownDigits", expectedDigits(hundredths), digits);
        checkValue("decimal points", 32'(expectedPoints), 32'(points));
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic resetTest();
        checkDisplay(0, 8'h00);
        finishTest("reset");
    endtask

    task automatic startStopTest();
        countFor(39);
        checkDisplay(enabledCycles / stopwatchPkg::TickDivide, 8'h00);
        repeat (30) @(negedge clk);
        checkDisplay(enabledCycles / stopwatchPkg::TickDivide, 8'h00);   // still held
        finishTest("start and stop");
    endtask

    task automatic resumeTest();
        stopwatchPkg::timeDigitsT digits;
        logic [7:0]               points;
        int                       used;

        pulseStartStop();
        readDisplay(digits, points, used);
        checkValue("decimal points", 32'(stopwatchPkg::SeparatorMask), 32'(points));
        repeat (20) @(negedge clk);
        pulseStartStop();
        enabledCycles += used + 21;
        checkDisplay(enabledCycles / stopwatchPkg::TickDivide, 8'h00);
        finishTest("resume");
    endtask

    task automatic lapTest();
        int lapValue;
        int used;
        int total;

        used = 0;
        pulseStartStop();
        repeat (49) @(negedge clk);
        pulseLap();
        enabledCycles += 50;
        lapValue = enabledCycles / stopwatchPkg::TickDivide;
        // count goes on behind the frozen display for 40 cycles
        total = 0;
        while (total < 40)
        begin
            checkDisplay(lapValue, stopwatchPkg::SeparatorMask);
            total += stopwatchPkg::DigitCount;
        end
        used = total;
        pulseLap();
        enabledCycles += used + 1;
        repeat (29) @(negedge clk);
        pulseStartStop();
        enabledCycles += 30;
        checkDisplay(enabledCycles / stopwatchPkg::TickDivide, 8'h00);
        finishTest("lap hold");
    endtask

    task automatic carryTest();
        stopwatchPkg::timeDigitsT digits;
        logic [7:0]               points;
        int                       used;

        pulseLap();             // clear from paused
        enabledCycles = 0;
        countFor(100 * stopwatchPkg::TickDivide);
        readDisplay(digits, points, used);
        checkValue("shownDigits", 32'h0000_0100, digits);   // 00:00:01.00
        finishTest("seconds carry");
    endtask

    task automatic clearTest();
        pulseLap();
        enabledCycles = 0;
        checkDisplay(0, 8'h00);
        countFor(23);
        checkDisplay(enabledCycles / stopwatchPkg::TickDivide, 8'h00);
        finishTest("clear");
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial
    begin
        clk           = 1'b0;
        reset_n       = 1'b0;
        startStop     = 1'b0;
        lap           = 1'b0;
        errorCount    = 0;
        testErrors    = 0;
        testCount     = 0;
        failedTests   = 0;
        enabledCycles = 0;

        repeat (10) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        resetTest();
        startStopTest();
        resumeTest();
        lapTest();
        carryTest();
        clearTest();

        $display("tests %0d, failed tests %0d, errors %0d", testCount, failedTests, errorCount);
        if (errorCount == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: files.f
hdl/stopwatchPkg.sv
hdl/stopwatchControl.sv
hdl/tickTimer.sv
hdl/bcdTimeCounter.sv
hdl/ledScan.sv
hdl/stopwatchTop.sv
tb/stopwatchProps.sv
tb/stopwatchTb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module stopwatchTb -f files.f -o simv
	./obj_dir/simv | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
